// ==== hdl/region_pkg.sv ====
`default_nettype none

package region_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BE_W   = DATA_W / 8;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BE_W-1:0]   be_t;

  // top address bits that select the local data window
  localparam int                  WIN_HI_W     = 12;
  localparam logic [WIN_HI_W-1:0] LOCAL_WINDOW = 12'h001;

  typedef enum logic {
    RESP_RAM,
    RESP_BUS
  } resp_src_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_EXT,
    OWN_CORE
  } arb_owner_e;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_CYCLE,
    WB_RESP
  } wb_state_e;

endpackage

`default_nettype wire

// ==== hdl/mem_port_if.sv ====
`default_nettype none

interface mem_port_if #(
  parameter int ADDR_BITS = 12
);

  logic                   req;
  logic                   gnt;
  logic                   rvalid;
  logic [ADDR_BITS-1:0]   addr;
  logic                   we;
  region_pkg::be_t        be;
  region_pkg::word_t      wdata;
  region_pkg::word_t      rdata;

  modport requester (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport responder (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

`default_nettype wire

// ==== hdl/sp_ram.sv ====
`default_nettype none

module sp_ram #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                    clk,
  input  logic                    en_i,
  input  logic [RAM_ADDR_W-1:0]   addr_i,
  input  logic                    we_i,
  input  region_pkg::be_t         be_i,
  input  region_pkg::word_t       wdata_i,
  output region_pkg::word_t       rdata_o
);

  localparam int NUM_WORDS = 2 ** RAM_ADDR_W;

  region_pkg::word_t mem [0:NUM_WORDS-1];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      // per-byte write enables
      for (int b = 0; b < region_pkg::BE_W; b++)
      begin
        if (we_i && be_i[b])
        begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      // read before write, data held until the next access
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ram_arbiter.sv ====
`default_nettype none

module ram_arbiter #(
  parameter int RAM_ADDR_W  = 12,
  parameter int CORE_WRITES = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,

  mem_port_if.responder           ext_port,
  mem_port_if.responder           core_port,

  output logic                    ram_en_o,
  output logic [RAM_ADDR_W-1:0]   ram_addr_o,
  output logic                    ram_we_o,
  output region_pkg::be_t         ram_be_o,
  output region_pkg::word_t       ram_wdata_o,
  input  region_pkg::word_t       ram_rdata_i
);

  logic                   core_we;
  region_pkg::be_t        core_be;
  region_pkg::word_t      core_wdata;
  region_pkg::arb_owner_e owner_q;

  if (CORE_WRITES != 0)
  begin : g_core_rw
    assign core_we    = core_port.we;
    assign core_be    = core_port.be;
    assign core_wdata = core_port.wdata;
  end
  else
  begin : g_core_ro
    // fetch side, full-word reads
    assign core_we    = 1'b0;
    assign core_be    = '1;
    assign core_wdata = '0;
  end

  // external port wins, core waits
  assign ext_port.gnt  = ext_port.req;
  assign core_port.gnt = ~ext_port.req;

  assign ram_en_o    = ext_port.req | core_port.req;
  assign ram_addr_o  = ext_port.req ? ext_port.addr  : core_port.addr;
  assign ram_we_o    = ext_port.req ? ext_port.we    : core_we;
  assign ram_be_o    = ext_port.req ? ext_port.be    : core_be;
  assign ram_wdata_o = ext_port.req ? ext_port.wdata : core_wdata;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      owner_q <= region_pkg::OWN_NONE;
    end
    else if (ext_port.req)
    begin
      owner_q <= region_pkg::OWN_EXT;
    end
    else if (core_port.req)
    begin
      owner_q <= region_pkg::OWN_CORE;
    end
    else
    begin
      owner_q <= region_pkg::OWN_NONE;
    end
  end

  assign ext_port.rvalid  = (owner_q == region_pkg::OWN_EXT);
  assign core_port.rvalid = (owner_q == region_pkg::OWN_CORE);
  assign ext_port.rdata   = (owner_q == region_pkg::OWN_EXT)  ? ram_rdata_i : '0;
  assign core_port.rdata  = (owner_q == region_pkg::OWN_CORE) ? ram_rdata_i : '0;

endmodule

`default_nettype wire

// ==== hdl/wb_mem_slave.sv ====
`default_nettype none

module wb_mem_slave #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  region_pkg::addr_t   adr_i,
  input  region_pkg::be_t     sel_i,
  input  region_pkg::word_t   dat_i,
  output region_pkg::word_t   dat_o,
  output logic                ack_o,

  mem_port_if.requester       mem
);

  logic ack_q;

  // one request per strobe, none in the ack cycle
  assign mem.req   = cyc_i & stb_i & ~ack_q;
  assign mem.addr  = adr_i[RAM_ADDR_W+1:2];
  assign mem.we    = we_i;
  assign mem.be    = sel_i;
  assign mem.wdata = dat_i;

  // lines up with rvalid from the arbiter
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= mem.req & mem.gnt;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = mem.rdata;

endmodule

`default_nettype wire

// ==== hdl/wb_bus_master.sv ====
`default_nettype none

module wb_bus_master (
  input  logic                clk,
  input  logic                rst_n,

  mem_port_if.responder       core,

  output logic                cyc_o,
  output logic                stb_o,
  output logic                we_o,
  output region_pkg::addr_t   adr_o,
  output region_pkg::be_t     sel_o,
  output region_pkg::word_t   dat_o,
  input  region_pkg::word_t   dat_i,
  input  logic                ack_i
);

  region_pkg::wb_state_e state_q;
  logic                  we_q;
  region_pkg::addr_t     adr_q;
  region_pkg::be_t       sel_q;
  region_pkg::word_t     wdata_q;
  region_pkg::word_t     rdata_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= region_pkg::WB_IDLE;
    end
    else
    begin
      case (state_q)
        region_pkg::WB_IDLE:
        begin
          if (core.req)
          begin
            state_q <= region_pkg::WB_CYCLE;
          end
        end
        region_pkg::WB_CYCLE:
        begin
          if (ack_i)
          begin
            state_q <= region_pkg::WB_RESP;
          end
        end
        default:
        begin
          state_q <= region_pkg::WB_IDLE;
        end
      endcase
    end
  end

  // request fields and read data
  always_ff @(posedge clk)
  begin
    if (state_q == region_pkg::WB_IDLE && core.req)
    begin
      we_q    <= core.we;
      adr_q   <= core.addr;
      sel_q   <= core.be;
      wdata_q <= core.wdata;
    end
    if (state_q == region_pkg::WB_CYCLE && ack_i)
    begin
      rdata_q <= dat_i;
    end
  end

  // busy means no grant
  assign core.gnt    = (state_q == region_pkg::WB_IDLE);
  assign core.rvalid = (state_q == region_pkg::WB_RESP);
  assign core.rdata  = rdata_q;

  assign cyc_o = (state_q == region_pkg::WB_CYCLE);
  assign stb_o = (state_q == region_pkg::WB_CYCLE);
  assign we_o  = we_q;
  assign adr_o = adr_q;
  assign sel_o = sel_q;
  assign dat_o = wdata_q;

endmodule

`default_nettype wire

// ==== hdl/lsu_route_ctrl.sv ====
`default_nettype none

module lsu_route_ctrl #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                req_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  input  region_pkg::addr_t   addr_i,
  input  logic                we_i,
  input  region_pkg::be_t     be_i,
  input  region_pkg::word_t   wdata_i,
  output region_pkg::word_t   rdata_o,

  mem_port_if.requester       ram_port,
  mem_port_if.requester       bus_port
);

  logic                  is_local;
  logic                  hold_local;
  logic                  bus_pend_q;
  region_pkg::resp_src_e src_q;

  assign is_local = addr_i[region_pkg::ADDR_W-1 -: region_pkg::WIN_HI_W]
                    == region_pkg::LOCAL_WINDOW;

  // a local access must not overtake a bus response still on its way
  assign hold_local = bus_pend_q & ~bus_port.rvalid;

  assign ram_port.req   = req_i & is_local & ~hold_local;
  assign ram_port.addr  = addr_i[RAM_ADDR_W+1:2];
  assign ram_port.we    = we_i;
  assign ram_port.be    = be_i;
  assign ram_port.wdata = wdata_i;

  assign bus_port.req   = req_i & ~is_local;
  assign bus_port.addr  = addr_i;
  assign bus_port.we    = we_i;
  assign bus_port.be    = be_i;
  assign bus_port.wdata = wdata_i;

  assign gnt_o = (ram_port.req & ram_port.gnt) | (bus_port.req & bus_port.gnt);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      src_q      <= region_pkg::RESP_RAM;
      bus_pend_q <= 1'b0;
    end
    else
    begin
      if (req_i && gnt_o)
      begin
        src_q <= is_local ? region_pkg::RESP_RAM : region_pkg::RESP_BUS;
      end
      if (bus_port.req && bus_port.gnt)
      begin
        bus_pend_q <= 1'b1;
      end
      else if (bus_port.rvalid)
      begin
        bus_pend_q <= 1'b0;
      end
    end
  end

  // response comes from whichever target took the last request
  assign rvalid_o = (src_q == region_pkg::RESP_BUS) ? bus_port.rvalid : ram_port.rvalid;
  assign rdata_o  = (src_q == region_pkg::RESP_BUS) ? bus_port.rdata : ram_port.rdata;

endmodule

`default_nettype wire

// ==== hdl/core_mem_region.sv ====
`default_nettype none

module core_mem_region #(
  parameter int RAM_ADDR_W = 12
) (
  input  logic                clk,
  input  logic                rst_n,

  // core fetch
  input  logic                instr_req_i,
  output logic                instr_gnt_o,
  output logic                instr_rvalid_o,
  input  region_pkg::addr_t   instr_addr_i,
  output region_pkg::word_t   instr_rdata_o,

  // core load/store
  input  logic                data_req_i,
  output logic                data_gnt_o,
  output logic                data_rvalid_o,
  input  region_pkg::addr_t   data_addr_i,
  input  logic                data_we_i,
  input  region_pkg::be_t     data_be_i,
  input  region_pkg::word_t   data_wdata_i,
  output region_pkg::word_t   data_rdata_o,

  // instruction RAM slave
  input  logic                wbi_cyc_i,
  input  logic                wbi_stb_i,
  input  logic                wbi_we_i,
  input  region_pkg::addr_t   wbi_adr_i,
  input  region_pkg::be_t     wbi_sel_i,
  input  region_pkg::word_t   wbi_dat_i,
  output region_pkg::word_t   wbi_dat_o,
  output logic                wbi_ack_o,

  // data RAM slave
  input  logic                wbd_cyc_i,
  input  logic                wbd_stb_i,
  input  logic                wbd_we_i,
  input  region_pkg::addr_t   wbd_adr_i,
  input  region_pkg::be_t     wbd_sel_i,
  input  region_pkg::word_t   wbd_dat_i,
  output region_pkg::word_t   wbd_dat_o,
  output logic                wbd_ack_o,

  // external bus master
  output logic                wbm_cyc_o,
  output logic                wbm_stb_o,
  output logic                wbm_we_o,
  output region_pkg::addr_t   wbm_adr_o,
  output region_pkg::be_t     wbm_sel_o,
  output region_pkg::word_t   wbm_dat_o,
  input  region_pkg::word_t   wbm_dat_i,
  input  logic                wbm_ack_i
);

  logic                   instr_ram_en;
  logic [RAM_ADDR_W-1:0]  instr_ram_addr;
  logic                   instr_ram_we;
  region_pkg::be_t        instr_ram_be;
  region_pkg::word_t      instr_ram_wdata;
  region_pkg::word_t      instr_ram_rdata;

  logic                   data_ram_en;
  logic [RAM_ADDR_W-1:0]  data_ram_addr;
  logic                   data_ram_we;
  region_pkg::be_t        data_ram_be;
  region_pkg::word_t      data_ram_wdata;
  region_pkg::word_t      data_ram_rdata;

  mem_port_if #(.ADDR_BITS(RAM_ADDR_W))         fetch_port ();
  mem_port_if #(.ADDR_BITS(RAM_ADDR_W))         wbi_port ();
  mem_port_if #(.ADDR_BITS(RAM_ADDR_W))         wbd_port ();
  mem_port_if #(.ADDR_BITS(RAM_ADDR_W))         lsu_ram_port ();
  mem_port_if #(.ADDR_BITS(region_pkg::ADDR_W)) lsu_bus_port ();

  // fetch is read only, we/be/wdata stay open
  assign fetch_port.req  = instr_req_i;
  assign fetch_port.addr = instr_addr_i[RAM_ADDR_W+1:2];
  assign instr_gnt_o     = fetch_port.gnt;
  assign instr_rvalid_o  = fetch_port.rvalid;
  assign instr_rdata_o   = fetch_port.rdata;

  lsu_route_ctrl #(.RAM_ADDR_W(RAM_ADDR_W)) lsu_route_ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (data_req_i),
    .gnt_o    (data_gnt_o),
    .rvalid_o (data_rvalid_o),
    .addr_i   (data_addr_i),
    .we_i     (data_we_i),
    .be_i     (data_be_i),
    .wdata_i  (data_wdata_i),
    .rdata_o  (data_rdata_o),
    .ram_port (lsu_ram_port),
    .bus_port (lsu_bus_port)
  );

  wb_bus_master wb_bus_master_i (
    .clk   (clk),
    .rst_n (rst_n),
    .core  (lsu_bus_port),
    .cyc_o (wbm_cyc_o),
    .stb_o (wbm_stb_o),
    .we_o  (wbm_we_o),
    .adr_o (wbm_adr_o),
    .sel_o (wbm_sel_o),
    .dat_o (wbm_dat_o),
    .dat_i (wbm_dat_i),
    .ack_i (wbm_ack_i)
  );

  wb_mem_slave #(.RAM_ADDR_W(RAM_ADDR_W)) wbi_slave_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc_i (wbi_cyc_i),
    .stb_i (wbi_stb_i),
    .we_i  (wbi_we_i),
    .adr_i (wbi_adr_i),
    .sel_i (wbi_sel_i),
    .dat_i (wbi_dat_i),
    .dat_o (wbi_dat_o),
    .ack_o (wbi_ack_o),
    .mem   (wbi_port)
  );

  wb_mem_slave #(.RAM_ADDR_W(RAM_ADDR_W)) wbd_slave_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc_i (wbd_cyc_i),
    .stb_i (wbd_stb_i),
    .we_i  (wbd_we_i),
    .adr_i (wbd_adr_i),
    .sel_i (wbd_sel_i),
    .dat_i (wbd_dat_i),
    .dat_o (wbd_dat_o),
    .ack_o (wbd_ack_o),
    .mem   (wbd_port)
  );

  ram_arbiter #(.RAM_ADDR_W(RAM_ADDR_W), .CORE_WRITES(0)) instr_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ext_port    (wbi_port),
    .core_port   (fetch_port),
    .ram_en_o    (instr_ram_en),
    .ram_addr_o  (instr_ram_addr),
    .ram_we_o    (instr_ram_we),
    .ram_be_o    (instr_ram_be),
    .ram_wdata_o (instr_ram_wdata),
    .ram_rdata_i (instr_ram_rdata)
  );

  ram_arbiter #(.RAM_ADDR_W(RAM_ADDR_W), .CORE_WRITES(1)) data_arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ext_port    (wbd_port),
    .core_port   (lsu_ram_port),
    .ram_en_o    (data_ram_en),
    .ram_addr_o  (data_ram_addr),
    .ram_we_o    (data_ram_we),
    .ram_be_o    (data_ram_be),
    .ram_wdata_o (data_ram_wdata),
    .ram_rdata_i (data_ram_rdata)
  );

  sp_ram #(.RAM_ADDR_W(RAM_ADDR_W)) instr_ram_i (
    .clk     (clk),
    .en_i    (instr_ram_en),
    .addr_i  (instr_ram_addr),
    .we_i    (instr_ram_we),
    .be_i    (instr_ram_be),
    .wdata_i (instr_ram_wdata),
    .rdata_o (instr_ram_rdata)
  );

  sp_ram #(.RAM_ADDR_W(RAM_ADDR_W)) data_ram_i (
    .clk     (clk),
    .en_i    (data_ram_en),
    .addr_i  (data_ram_addr),
    .we_i    (data_ram_we),
    .be_i    (data_ram_be),
    .wdata_i (data_ram_wdata),
    .rdata_o (data_ram_rdata)
  );

endmodule

`default_nettype wire

// ==== tb/tb_core_mem_region.sv ====
`default_nettype none

module tb_core_mem_region;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD    = 8;
  localparam int          GNT_TIMEOUT   = 32;
  localparam int          NUM_ACCESSES  = 160;
  localparam int          MAX_BUS_DELAY = 3;
  // worst case per access is the bus delay plus request, ack and response cycles
  localparam int          TIMEOUT_NS    = (NUM_ACCESSES * (MAX_BUS_DELAY + 4) + 40) * CLK_PERIOD;
  localparam logic [31:0] LOCAL_BASE    = 32'h0010_0000;
  localparam logic [31:0] BUS_BASE      = 32'h4000_0000;

  typedef struct packed {
    logic        is_bus;
    logic        is_read;
    logic [31:0] data;
    logic [31:0] due;
  } rsp_t;

  typedef struct packed {
    logic [31:0] adr;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] dat;
  } bus_req_t;

  logic        clk;
  logic        rst_n;
  logic        instr_req_i, instr_gnt_o, instr_rvalid_o;
  logic [31:0] instr_addr_i, instr_rdata_o;
  logic        data_req_i, data_gnt_o, data_rvalid_o, data_we_i;
  logic [31:0] data_addr_i, data_wdata_i, data_rdata_o;
  logic [3:0]  data_be_i;
  logic        wbi_cyc_i, wbi_stb_i, wbi_we_i, wbi_ack_o;
  logic [31:0] wbi_adr_i, wbi_dat_i, wbi_dat_o;
  logic [3:0]  wbi_sel_i;
  logic        wbd_cyc_i, wbd_stb_i, wbd_we_i, wbd_ack_o;
  logic [31:0] wbd_adr_i, wbd_dat_i, wbd_dat_o;
  logic [3:0]  wbd_sel_i;
  logic        wbm_cyc_o, wbm_stb_o, wbm_we_o, wbm_ack_i;
  logic [31:0] wbm_adr_o, wbm_dat_o, wbm_dat_i;
  logic [3:0]  wbm_sel_o;

  logic [31:0] lfsr_q = 32'h412e422d;
  logic [31:0] cyc_cnt = '0;
  logic        stim_started = 1'b0;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;

  // reference contents indexed by address bits 7:2
  logic [31:0] imem_ref [0:63];
  logic [31:0] dmem_ref [0:63];

  rsp_t        rsp_q [$];
  rsp_t        rsp_head;
  logic [31:0] rsp_exp;
  bus_req_t    bus_exp_q [$];
  bus_req_t    bus_exp;
  bus_req_t    bus_held;
  logic [31:0] bus_data_q [$];
  logic [31:0] ack_data;
  int          bus_delay;

  core_mem_region dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    cyc_cnt <= cyc_cnt + 1;

  // fibonacci lfsr on taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[31]};
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatch_cnt++;
    $display("MISMATCH at %0d ns: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    fail_cnt++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  task automatic drive_wb(input logic dport, input logic active, input logic we,
                          input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] dat);
    if (dport)
    begin
      wbd_cyc_i = active;
      wbd_stb_i = active;
      wbd_we_i  = we;
      wbd_adr_i = adr;
      wbd_sel_i = sel;
      wbd_dat_i = dat;
    end
    else
    begin
      wbi_cyc_i = active;
      wbi_stb_i = active;
      wbi_we_i  = we;
      wbi_adr_i = adr;
      wbi_sel_i = sel;
      wbi_dat_i = dat;
    end
  endtask

  // one classic cycle on wbi_ (dport 0) or wbd_ (dport 1)
  task automatic wb_access(input logic dport, input logic we, input logic [31:0] addr,
                           input logic [3:0] sel, input logic [31:0] dat);
    logic [5:0]  idx;
    logic [31:0] exp;
    idx = addr[7:2];
    drive_wb(dport, 1'b1, we, addr, sel, dat);
    @(negedge clk);
    assert (!(dport ? wbd_ack_o : wbi_ack_o))
      else report_failure("slave ack came in the strobe cycle");
    @(negedge clk);
    exp = dport ? dmem_ref[idx] : imem_ref[idx];
    assert (dport ? wbd_ack_o : wbi_ack_o)
      else report_failure("slave ack missing in the second cycle of the access");
    if (!we)
    begin
      assert ((dport ? wbd_dat_o : wbi_dat_o) === exp)
        else report_mismatch($sformatf("slave %0d read at %h gave %h, expected %h", dport,
                                       addr, dport ? wbd_dat_o : wbi_dat_o, exp));
    end
    else if (dport)
      dmem_ref[idx] = merge_bytes(dmem_ref[idx], dat, sel);
    else
      imem_ref[idx] = merge_bytes(imem_ref[idx], dat, sel);
    @(posedge clk);
    #1;
    drive_wb(dport, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic fetch_check(input logic [31:0] addr);
    int waited;
    waited = 0;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    @(negedge clk);
    while (!instr_gnt_o && waited < GNT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    assert (instr_gnt_o) else report_failure("no instr_gnt_o for a fetch");
    @(posedge clk);
    #1;
    instr_req_i = 1'b0;
    @(negedge clk);
    assert (instr_rvalid_o) else report_failure("instr_rvalid_o missing after the grant");
    assert (instr_rdata_o === imem_ref[addr[7:2]])
      else report_mismatch($sformatf("fetch at %h gave %h, expected %h", addr,
                                     instr_rdata_o, imem_ref[addr[7:2]]));
    @(posedge clk);
    #1;
  endtask

  // issues one load/store and leaves its response to the checker
  task automatic lsu_issue(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata);
    rsp_t r;
    int   waited;
    logic local_hit;
    logic granted;
    waited         = 0;
    local_hit      = (addr[31:20] == 12'h001);
    data_req_i     = 1'b1;
    data_addr_i    = addr;
    data_we_i      = we;
    data_be_i      = be;
    data_wdata_i   = wdata;
    @(negedge clk);
    while (!data_gnt_o && waited < GNT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    granted   = data_gnt_o;
    r.is_bus  = !local_hit;
    r.is_read = !we;
    r.due     = cyc_cnt + 1;
    r.data    = local_hit ? dmem_ref[addr[7:2]] : '0;
    @(posedge clk);
    #1;
    data_req_i = 1'b0;
    if (!granted)
      report_failure("no data_gnt_o for a load/store request");
    else
    begin
      if (local_hit && we)
        dmem_ref[addr[7:2]] = merge_bytes(dmem_ref[addr[7:2]], wdata, be);
      if (!local_hit)
        bus_exp_q.push_back({addr, we, be, wdata});
      rsp_q.push_back(r);
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (rsp_q.size() != 0 && waited < GNT_TIMEOUT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (rsp_q.size() != 0)
      report_failure("load/store responses still outstanding");
  endtask

  task automatic load_and_fetch_instr();
    for (int w = 0; w < 8; w++)
      wb_access(1'b0, 1'b1, w * 20, 4'hf, rand_bits(32));
    wb_access(1'b0, 1'b1, 32'h0, 4'b0101, rand_bits(32));
    wb_access(1'b0, 1'b0, 32'h0, 4'hf, 32'h0);
    for (int w = 0; w < 8; w++)
      fetch_check(w * 20);
  endtask

  task automatic data_ram_both_paths();
    for (int w = 0; w < 24; w++)
      wb_access(1'b1, 1'b1, w * 4, 4'hf, rand_bits(32));
    for (int w = 0; w < 8; w++)
      lsu_issue(LOCAL_BASE + w * 4, 1'b1, 4'(rand_bits(4)), rand_bits(32));
    drain_responses();
    for (int w = 8; w < 16; w++)
      wb_access(1'b1, 1'b1, w * 4, 4'(rand_bits(4)), rand_bits(32));
    for (int w = 0; w < 16; w++)
      lsu_issue(LOCAL_BASE + w * 4, 1'b0, 4'hf, 32'h0);
    drain_responses();
    for (int w = 0; w < 16; w++)
      wb_access(1'b1, 1'b0, w * 4, 4'hf, 32'h0);
  endtask

  task automatic bus_accesses();
    for (int k = 0; k < 6; k++)
      lsu_issue(BUS_BASE | (rand_bits(10) << 2), rand_bits(1) == 1, 4'(rand_bits(4)),
                rand_bits(32));
    drain_responses();
  endtask

  task automatic contention_cases();
    for (int k = 0; k < 4; k++)
    begin
      fork
        wb_access(1'b1, (k % 2) == 0, (16 + k) * 4, 4'hf, rand_bits(32));
        lsu_issue(LOCAL_BASE + (20 + k) * 4, (k % 2) == 1, 4'(rand_bits(4)), rand_bits(32));
        begin
          @(negedge clk);
          assert (!data_gnt_o) else report_failure("data_gnt_o high while wbd_ strobes");
        end
      join
      drain_responses();
    end
    for (int w = 16; w < 24; w++)
      lsu_issue(LOCAL_BASE + w * 4, 1'b0, 4'hf, 32'h0);
    drain_responses();
  endtask

  task automatic alternate_targets();
    for (int k = 0; k < 6; k++)
    begin
      lsu_issue(LOCAL_BASE + k * 4, 1'b0, 4'hf, 32'h0);
      lsu_issue(BUS_BASE | (rand_bits(8) << 2), 1'b0, 4'hf, 32'h0);
    end
    drain_responses();
  endtask

  // idle outputs before the first request and no grant during a bus cycle
  always @(negedge clk)
  begin
    if (!stim_started)
      assert (!(instr_rvalid_o | data_rvalid_o | wbi_ack_o | wbd_ack_o | wbm_cyc_o |
                wbm_stb_o))
        else report_failure("control output active before any request");
    if (rst_n && wbm_cyc_o)
      assert (!data_gnt_o) else report_failure("data_gnt_o given while a bus cycle is open");
  end

  // load/store responses in issue order
  always @(negedge clk)
  begin
    if (rst_n && data_rvalid_o)
    begin
      if (rsp_q.size() == 0)
        report_failure("data_rvalid_o with no load/store outstanding");
      else
      begin
        rsp_head = rsp_q.pop_front();
        rsp_exp  = rsp_head.data;
        if (rsp_head.is_bus && bus_data_q.size() == 0)
          report_failure("bus response without a bus ack");
        else if (rsp_head.is_bus)
          rsp_exp = bus_data_q.pop_front();
        else if (rsp_head.due != cyc_cnt)
          report_failure("local response not one cycle after the grant");
        if (rsp_head.is_bus || rsp_head.is_read)
          assert (data_rdata_o === rsp_exp)
            else report_mismatch($sformatf("load/store data %h, expected %h from %s",
                                           data_rdata_o, rsp_exp,
                                           rsp_head.is_bus ? "bus" : "data RAM"));
      end
    end
    else if (rst_n && rsp_q.size() != 0 && !rsp_q[0].is_bus && rsp_q[0].due == cyc_cnt)
      report_failure("local response missing one cycle after the grant");
  end

  // bus slave model acking after a random delay with random data
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n && wbm_cyc_o)
      begin
        assert (wbm_stb_o) else report_failure("wbm_cyc_o without wbm_stb_o");
        bus_held = {wbm_adr_o, wbm_we_o, wbm_sel_o, wbm_dat_o};
        if (bus_exp_q.size() == 0)
          report_failure("bus cycle with no access outstanding");
        else
        begin
          bus_exp = bus_exp_q.pop_front();
          assert (wbm_adr_o === bus_exp.adr && wbm_we_o === bus_exp.we &&
                  wbm_sel_o === bus_exp.sel && (!bus_exp.we || wbm_dat_o === bus_exp.dat))
            else report_mismatch($sformatf("bus cycle %h/%b/%h/%h, expected %h/%b/%h/%h",
                                           wbm_adr_o, wbm_we_o, wbm_sel_o, wbm_dat_o,
                                           bus_exp.adr, bus_exp.we, bus_exp.sel,
                                           bus_exp.dat));
        end
        bus_delay = rand_bits(2);
        repeat (bus_delay)
        begin
          @(negedge clk);
          assert (wbm_cyc_o && wbm_stb_o &&
                  bus_held == {wbm_adr_o, wbm_we_o, wbm_sel_o, wbm_dat_o})
            else report_failure("bus master changed its outputs before ack");
        end
        @(posedge clk);
        #1;
        ack_data  = rand_bits(32);
        wbm_ack_i = 1'b1;
        wbm_dat_i = ack_data;
        bus_data_q.push_back(ack_data);
        @(posedge clk);
        #1;
        wbm_ack_i = 1'b0;
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    report_failure("run did not finish within the watchdog limit");
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    rst_n       = 1'b0;
    instr_req_i = 1'b0;
    instr_addr_i = '0;
    data_req_i  = 1'b0;
    data_addr_i = '0;
    data_we_i   = 1'b0;
    data_be_i   = '0;
    data_wdata_i = '0;
    drive_wb(1'b0, 1'b0, 1'b0, '0, '0, '0);
    drive_wb(1'b1, 1'b0, 1'b0, '0, '0, '0);
    wbm_ack_i   = 1'b0;
    wbm_dat_i   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    stim_started = 1'b1;
    load_and_fetch_instr();
    data_ram_both_paths();
    bus_accesses();
    contention_cases();
    alternate_targets();
    repeat (4) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/region_pkg.sv
hdl/mem_port_if.sv
hdl/sp_ram.sv
hdl/ram_arbiter.sv
hdl/wb_mem_slave.sv
hdl/wb_bus_master.sv
hdl/lsu_route_ctrl.sv
hdl/core_mem_region.sv
tb/tb_core_mem_region.sv
